/* minn_frame_detector.f */
+incdir+rtl
+incdir+dv
rtl/minn_pkg.sv
rtl/minn_metric_engine.sv
rtl/minn_peak_gate.sv
rtl/minn_align_buffer.sv
rtl/minn_frame_detector.sv
dv/tb_minn_frame_detector.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the frame detector testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f minn_frame_detector.f \
    --top-module tb_minn_frame_detector \
    -o sim_minn

./obj_dir/sim_minn > sim.log
cat sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

/* dv/minn_ref_model.svh */
`ifndef MINN_REF_MODEL_SVH
`define MINN_REF_MODEL_SVH

// Real part of x[m-Q] * conj(x[m]) over both antennas
function automatic longint ref_product(input int m);
    int k;
    k = m - Q;
    return longint'(s0i[k]) * s0i[m] + longint'(s0q[k]) * s0q[m]
         + longint'(s1i[k]) * s1i[m] + longint'(s1q[k]) * s1q[m];
endfunction

function automatic longint ref_energy(input int m);
    return longint'(s0i[m]) * s0i[m] + longint'(s0q[m]) * s0q[m]
         + longint'(s1i[m]) * s1i[m] + longint'(s1q[m]) * s1q[m];
endfunction

// Metric of newest sample n, window starting at n - WD
function automatic void ref_metric(input int n, output longint r, output longint e);
    longint sum_a;
    longint sum_b;
    sum_a = 0;
    sum_b = 0;
    e     = 0;
    for (int m = n - Q + 1; m <= n; m++) begin
        sum_b += ref_product(m);
        sum_a += ref_product(m - 2 * Q);
    end
    for (int m = n - 3 * Q + 1; m <= n; m++) begin
        e += ref_energy(m);
    end
    r = sum_a + sum_b;
    if (r < 0) begin
        r = 0;
    end
endfunction

function automatic bit ref_above(input longint r, input longint e);
    return (e != 0) && (r * 32768 >= e * longint'(`MINN_K_Q15));
endfunction

// Gate replay for a stream with in_valid_i held high, returns the flag count
function automatic int predict_flags(input int n_smp);
    int     state;
    int     rearm_n;
    int     count;
    int     pk_idx;
    int     wr_idx;
    longint r;
    longint e;
    longint pk_r;
    longint pk_e;
    state   = 0;
    rearm_n = 0;
    count   = 0;
    pk_idx  = 0;
    pk_r    = 0;
    pk_e    = 0;
    for (int i = 0; i < MAX_SMP; i++) begin
        exp_flag[i] = 1'b0;
    end
    for (int n = WD; n < n_smp; n++) begin
        ref_metric(n, r, e);
        if (state == 2 && n >= rearm_n) begin
            state = 0;
        end
        if (state == 0) begin
            if (ref_above(r, e)) begin
                state  = 1;
                pk_r   = r;
                pk_e   = e;
                pk_idx = n - WD;
            end
        end else if (state == 1) begin
            if (ref_above(r, e)) begin
                // Later equal ratios win
                if (r * pk_e >= pk_r * e) begin
                    pk_r   = r;
                    pk_e   = e;
                    pk_idx = n - WD;
                end
            end else begin
                state   = 2;
                rearm_n = n + HOLDOFF + 1;
                // Mark lands two cycles after sample n was accepted
                wr_idx  = (n + 2 < n_smp) ? n + 2 : n_smp;
                if (wr_idx - pk_idx <= BUF_LEN && pk_idx < n_smp - BUF_LEN) begin
                    exp_flag[pk_idx] = 1'b1;
                    count++;
                end
            end
        end
    end
    return count;
endfunction

`endif

/* dv/tb_minn_frame_detector.sv */
`timescale 1ns/1ps
`include "minn_settings.svh"

module tb_minn_frame_detector import minn_pkg::*; ();

    localparam int Q        = `MINN_Q;
    localparam int BUF_LEN  = `MINN_BUF_LEN;
    localparam int WD       = `MINN_WINDOW_DELAY;
    localparam int HOLDOFF  = `MINN_HOLDOFF;
    localparam int MAX_SMP  = 512;
    localparam int PRE_AMP  = 1000;
    localparam int NOISE    = 1500;

    // Reset check plus every stream below
    localparam int TOTAL_SAMPLES  = 20 + 300 + 200 + 300 + 304 + 336 + 464;
    localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 4 + BUF_LEN;

    logic clk;
    logic rst_n;
    logic in_valid_i;
    iq_t  ch0_i_i;
    iq_t  ch0_q_i;
    iq_t  ch1_i_i;
    iq_t  ch1_q_i;
    logic out_valid_o;
    iq_t  out_ch0_i_o;
    iq_t  out_ch0_q_o;
    iq_t  out_ch1_i_o;
    iq_t  out_ch1_q_o;
    logic detect_flag_o;

    int          s0i [MAX_SMP];
    int          s0q [MAX_SMP];
    int          s1i [MAX_SMP];
    int          s1q [MAX_SMP];
    bit          exp_flag [MAX_SMP];
    int unsigned lcg_state = 33;
    int          error_cnt = 0;
    int          check_cnt = 0;
    int          cycle_cnt = 0;

    `include "minn_ref_model.svh"

    minn_frame_detector uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid_i),
        .ch0_i_i       (ch0_i_i),
        .ch0_q_i       (ch0_q_i),
        .ch1_i_i       (ch1_i_i),
        .ch1_q_i       (ch1_q_i),
        .out_valid_o   (out_valid_o),
        .out_ch0_i_o   (out_ch0_i_o),
        .out_ch0_q_o   (out_ch0_q_o),
        .out_ch1_i_o   (out_ch1_i_o),
        .out_ch1_q_o   (out_ch1_q_o),
        .detect_flag_o (detect_flag_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_iq(input int amp);
        int unsigned span;
        span = 2 * amp + 1;
        return int'((lcg_next() >> 8) % span) - amp;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        check_cnt++;
        if (expected != actual) begin
            error_cnt++;
            $display("** Error at time %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    function automatic void fill_noise(input int start, input int len, input int amp);
        for (int k = start; k < start + len; k++) begin
            s0i[k] = rand_iq(amp);
            s0q[k] = rand_iq(amp);
            s1i[k] = rand_iq(amp);
            s1q[k] = rand_iq(amp);
        end
    endfunction

    // Quarters A A -A -A followed by extra quarters of +A
    function automatic void build_preamble(input int start, input int extra);
        int a0i;
        int a0q;
        int a1i;
        int a1q;
        int p;
        int sgn;
        for (int k = 0; k < Q; k++) begin
            a0i = rand_iq(PRE_AMP);
            a0q = rand_iq(PRE_AMP);
            a1i = rand_iq(PRE_AMP);
            a1q = rand_iq(PRE_AMP);
            for (int j = 0; j < 4 + extra; j++) begin
                p      = start + j * Q + k;
                sgn    = (j == 2 || j == 3) ? -1 : 1;
                s0i[p] = sgn * a0i;
                s0q[p] = sgn * a0q;
                s1i[p] = sgn * a1i;
                s1q[p] = sgn * a1q;
            end
        end
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        in_valid_i = 1'b0;
        ch0_i_i    = '0;
        ch0_q_i    = '0;
        ch1_i_i    = '0;
        ch1_q_i    = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Drives one stream and checks every replayed sample and its flag
    task automatic run_stream(input int n_smp, input bit use_gaps);
        int idx;
        int out_k;
        int accepted;
        int idle;
        idx      = 0;
        out_k    = 0;
        accepted = 0;
        idle     = 0;
        while (idle < 4) begin
            @(negedge clk);
            if (out_valid_o) begin
                check_value("accepted_before_output", out_k + BUF_LEN + 1, accepted);
                check_value("out_ch0_i_o", s0i[out_k], out_ch0_i_o);
                check_value("out_ch0_q_o", s0q[out_k], out_ch0_q_o);
                check_value("out_ch1_i_o", s1i[out_k], out_ch1_i_o);
                check_value("out_ch1_q_o", s1q[out_k], out_ch1_q_o);
                check_value("detect_flag_o", exp_flag[out_k], detect_flag_o);
                out_k++;
            end else begin
                check_value("detect_flag_o", 0, detect_flag_o);
            end
            if (idx < n_smp && (!use_gaps || (lcg_next() % 32'd4) != 0)) begin
                in_valid_i = 1'b1;
                ch0_i_i    = iq_t'(s0i[idx]);
                ch0_q_i    = iq_t'(s0q[idx]);
                ch1_i_i    = iq_t'(s1i[idx]);
                ch1_q_i    = iq_t'(s1q[idx]);
                accepted++;
                idx++;
            end else begin
                in_valid_i = 1'b0;
                if (idx >= n_smp) begin
                    idle++;
                end
            end
        end
        check_value("out_count", n_smp - BUF_LEN, out_k);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        apply_reset();
        repeat (20) begin
            @(negedge clk);
            check_value("out_valid_o", 0, out_valid_o);
            check_value("detect_flag_o", 0, detect_flag_o);
        end
    endtask

    task automatic test_replay();
        apply_reset();
        fill_noise(0, 300, 2047);
        void'(predict_flags(300));
        run_stream(300, 1'b1);
    endtask

    task automatic test_quiet();
        apply_reset();
        fill_noise(0, 200, 0);
        void'(predict_flags(200));
        run_stream(200, 1'b0);
        apply_reset();
        fill_noise(0, 300, 6);
        check_value("model_detections", 0, predict_flags(300));
        run_stream(300, 1'b0);
    endtask

    task automatic test_detection();
        apply_reset();
        fill_noise(0, 304, NOISE);
        build_preamble(40, 0);
        check_value("model_detections", 1, predict_flags(304));
        run_stream(304, 1'b0);
    endtask

    task automatic test_holdoff();
        // Second preamble overlaps the first with peaks 2Q apart
        apply_reset();
        fill_noise(0, 336, NOISE);
        build_preamble(40, 2);
        check_value("model_detections", 1, predict_flags(336));
        run_stream(336, 1'b0);
        // Peaks far beyond the holdoff
        apply_reset();
        fill_noise(0, 464, NOISE);
        build_preamble(40, 0);
        build_preamble(200, 0);
        check_value("model_detections", 2, predict_flags(464));
        run_stream(464, 1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid_i = 1'b0;
        ch0_i_i    = '0;
        ch0_q_i    = '0;
        ch1_i_i    = '0;
        ch1_q_i    = '0;
        test_reset_state();
        test_replay();
        test_quiet();
        test_detection();
        test_holdoff();
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* rtl/minn_frame_detector.sv */
`timescale 1ns/1ps
`include "minn_settings.svh"

module minn_frame_detector import minn_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid_i,
    input  iq_t  ch0_i_i,
    input  iq_t  ch0_q_i,
    input  iq_t  ch1_i_i,
    input  iq_t  ch1_q_i,
    output logic out_valid_o,
    output iq_t  out_ch0_i_o,
    output iq_t  out_ch0_q_o,
    output iq_t  out_ch1_i_o,
    output iq_t  out_ch1_q_o,
    output logic detect_flag_o
);

    // Metric engine to peak gate
    logic    metric_valid;
    corr_t   metric_r;
    energy_t metric_energy;
    idx_t    metric_idx;

    // Peak gate to align buffer
    logic mark_valid;
    idx_t mark_idx;

    minn_metric_engine u_metric_engine (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid_i      (in_valid_i),
        .ch0_i_i         (ch0_i_i),
        .ch0_q_i         (ch0_q_i),
        .ch1_i_i         (ch1_i_i),
        .ch1_q_i         (ch1_q_i),
        .metric_valid_o  (metric_valid),
        .metric_r_o      (metric_r),
        .metric_energy_o (metric_energy),
        .metric_idx_o    (metric_idx)
    );

    minn_peak_gate u_peak_gate (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid_i      (in_valid_i),
        .metric_valid_i  (metric_valid),
        .metric_r_i      (metric_r),
        .metric_energy_i (metric_energy),
        .metric_idx_i    (metric_idx),
        .mark_valid_o    (mark_valid),
        .mark_idx_o      (mark_idx)
    );

    minn_align_buffer u_align_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid_i    (in_valid_i),
        .ch0_i_i       (ch0_i_i),
        .ch0_q_i       (ch0_q_i),
        .ch1_i_i       (ch1_i_i),
        .ch1_q_i       (ch1_q_i),
        .mark_valid_i  (mark_valid),
        .mark_idx_i    (mark_idx),
        .out_valid_o   (out_valid_o),
        .out_ch0_i_o   (out_ch0_i_o),
        .out_ch0_q_o   (out_ch0_q_o),
        .out_ch1_i_o   (out_ch1_i_o),
        .out_ch1_q_o   (out_ch1_q_o),
        .detect_flag_o (detect_flag_o)
    );

endmodule

/* rtl/minn_align_buffer.sv */
`timescale 1ns/1ps
`include "minn_settings.svh"

module minn_align_buffer import minn_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid_i,
    input  iq_t  ch0_i_i,
    input  iq_t  ch0_q_i,
    input  iq_t  ch1_i_i,
    input  iq_t  ch1_q_i,
    input  logic mark_valid_i,
    input  idx_t mark_idx_i,
    output logic out_valid_o,
    output iq_t  out_ch0_i_o,
    output iq_t  out_ch0_q_o,
    output iq_t  out_ch1_i_o,
    output iq_t  out_ch1_q_o,
    output logic detect_flag_o
);

    localparam int             BUF_LEN     = `MINN_BUF_LEN;
    localparam int             PTR_W       = $clog2(BUF_LEN);
    localparam logic [PTR_W:0] BUF_LEN_EXT = (PTR_W + 1)'(BUF_LEN);

    iq_t              mem_ch0_i [BUF_LEN];
    iq_t              mem_ch0_q [BUF_LEN];
    iq_t              mem_ch1_i [BUF_LEN];
    iq_t              mem_ch1_q [BUF_LEN];
    logic [BUF_LEN-1:0] flag_mem;

    logic [PTR_W-1:0] wr_ptr;
    idx_t             wr_idx;
    logic             full;

    idx_t             mark_age;
    logic [PTR_W:0]   mark_pos;
    logic [PTR_W-1:0] mark_ptr;
    logic             mark_hit, emit;

    // --------------------------------------------------
    // Map a mark index onto its ring slot
    // --------------------------------------------------
    always_comb begin
        // Age 1 is the newest entry, BUF_LEN the oldest
        mark_age = wr_idx - mark_idx_i;
        mark_hit = mark_valid_i && (mark_age != '0) && (mark_age <= idx_t'(BUF_LEN));
        mark_pos = {1'b0, wr_ptr} + BUF_LEN_EXT - mark_age[PTR_W:0];
        if (mark_pos >= BUF_LEN_EXT) begin
            mark_pos = mark_pos - BUF_LEN_EXT;
        end
        mark_ptr = mark_pos[PTR_W-1:0];
        emit     = in_valid_i && full;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            wr_idx        <= '0;
            full          <= 1'b0;
            out_valid_o   <= 1'b0;
            detect_flag_o <= 1'b0;
        end else begin
            out_valid_o <= emit;
            // A mark landing on the slot being read this cycle is forwarded
            detect_flag_o <= emit && (flag_mem[wr_ptr] || (mark_hit && (mark_ptr == wr_ptr)));
            if (in_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_LEN - 1)) ? '0 : wr_ptr + 1'b1;
                wr_idx <= wr_idx + 1'b1;
                if (wr_ptr == PTR_W'(BUF_LEN - 1)) begin
                    full <= 1'b1;
                end
            end
        end
    end

    // Oldest entry is read before the new sample overwrites it
    always_ff @(posedge clk) begin
        if (mark_hit) begin
            flag_mem[mark_ptr] <= 1'b1;
        end
        if (in_valid_i) begin
            if (full) begin
                out_ch0_i_o <= mem_ch0_i[wr_ptr];
                out_ch0_q_o <= mem_ch0_q[wr_ptr];
                out_ch1_i_o <= mem_ch1_i[wr_ptr];
                out_ch1_q_o <= mem_ch1_q[wr_ptr];
            end
            mem_ch0_i[wr_ptr] <= ch0_i_i;
            mem_ch0_q[wr_ptr] <= ch0_q_i;
            mem_ch1_i[wr_ptr] <= ch1_i_i;
            mem_ch1_q[wr_ptr] <= ch1_q_i;
            flag_mem[wr_ptr]  <= 1'b0;
        end
    end

endmodule

/* rtl/minn_peak_gate.sv */
`timescale 1ns/1ps
`include "minn_settings.svh"

module minn_peak_gate import minn_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  logic    metric_valid_i,
    input  corr_t   metric_r_i,
    input  energy_t metric_energy_i,
    input  idx_t    metric_idx_i,
    output logic    mark_valid_o,
    output idx_t    mark_idx_o
);

    localparam int HOLD_W = $clog2(`MINN_HOLDOFF + 1);
    localparam int THR_W  = ENERGY_W + 16;
    localparam int CMP_W  = RATIO_W + ENERGY_W;

    gate_state_t       state;
    logic [HOLD_W-1:0] hold_cnt;

    // Best ratio seen while the gate is open
    ratio_t  peak_ratio;
    energy_t peak_energy;
    idx_t    peak_idx;

    ratio_t           ratio;
    logic [THR_W-1:0] thr;
    logic [CMP_W-1:0] lhs, rhs;
    logic             above, open_now, replace_now, close_now;

    // --------------------------------------------------
    // Threshold test and peak comparison
    // --------------------------------------------------
    always_comb begin
        ratio = ratio_t'(metric_r_i) << 15;
        thr   = metric_energy_i * THR_W'(`MINN_K_Q15);
        above = metric_valid_i && (metric_energy_i != '0) && (ratio >= thr);

        // ratio/energy >= peak_ratio/peak_energy without a divider
        lhs = ratio * peak_energy;
        rhs = peak_ratio * metric_energy_i;

        open_now    = (state == GATE_ARMED) && above;
        replace_now = (state == GATE_OPEN) && above && (lhs >= rhs);
        close_now   = (state == GATE_OPEN) && metric_valid_i && !above;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= GATE_ARMED;
            hold_cnt     <= '0;
            mark_valid_o <= 1'b0;
        end else begin
            mark_valid_o <= close_now;
            case (state)
                GATE_ARMED: begin
                    if (open_now) begin
                        state <= GATE_OPEN;
                    end
                end
                GATE_OPEN: begin
                    if (close_now) begin
                        state    <= GATE_HOLDOFF;
                        hold_cnt <= '0;
                    end
                end
                GATE_HOLDOFF: begin
                    // Counts accepted input samples, not metric strobes
                    if (in_valid_i) begin
                        if (hold_cnt == HOLD_W'(`MINN_HOLDOFF - 1)) begin
                            state <= GATE_ARMED;
                        end else begin
                            hold_cnt <= hold_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= GATE_ARMED;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (open_now || replace_now) begin
            peak_ratio  <= ratio;
            peak_energy <= metric_energy_i;
            peak_idx    <= metric_idx_i;
        end
        if (close_now) begin
            mark_idx_o <= peak_idx;
        end
    end

endmodule

/* rtl/minn_metric_engine.sv */
`timescale 1ns/1ps
`include "minn_settings.svh"

module minn_metric_engine import minn_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  iq_t     ch0_i_i,
    input  iq_t     ch0_q_i,
    input  iq_t     ch1_i_i,
    input  iq_t     ch1_q_i,
    output logic    metric_valid_o,
    output corr_t   metric_r_o,
    output energy_t metric_energy_o,
    output idx_t    metric_idx_o
);

    localparam int Q       = `MINN_Q;
    localparam int P_LEN   = 2 * Q;
    localparam int E_LEN   = 3 * Q;
    localparam int Q_PTR_W = $clog2(Q);
    localparam int P_PTR_W = $clog2(P_LEN);
    localparam int E_PTR_W = $clog2(E_LEN);
    localparam int Q_CNT_W = $clog2(Q + 1);
    localparam int P_CNT_W = $clog2(P_LEN + 1);
    localparam int E_CNT_W = $clog2(E_LEN + 1);
    localparam int E_SMP_W = 2 * IQ_W + 1;

    // Raw sample history for x[n-Q]
    iq_t                hist_ch0_i [Q];
    iq_t                hist_ch0_q [Q];
    iq_t                hist_ch1_i [Q];
    iq_t                hist_ch1_q [Q];
    logic [Q_PTR_W-1:0] hist_ptr;
    logic [Q_CNT_W-1:0] hist_cnt;

    // Products delayed by 2Q on their way to SumA
    prod_t              dly_ring [P_LEN];
    logic [P_PTR_W-1:0] dly_ptr;
    logic [P_CNT_W-1:0] dly_cnt;

    // Only the real part of the correlation feeds the metric
    prod_t              b_ring [Q];
    logic [Q_PTR_W-1:0] b_ptr;
    logic [Q_CNT_W-1:0] b_cnt;
    corr_t              sum_b;

    prod_t              a_ring [Q];
    logic [Q_PTR_W-1:0] a_ptr;
    logic [Q_CNT_W-1:0] a_cnt;
    corr_t              sum_a;

    logic [E_SMP_W-1:0] e_ring [E_LEN];
    logic [E_PTR_W-1:0] e_ptr;
    logic [E_CNT_W-1:0] e_cnt;
    energy_t            energy_sum;

    idx_t sample_idx;

    iq_t                d0_i, d0_q, d1_i, d1_q;
    logic               hist_full, dly_full, dly_valid, b_full, a_full, e_full, win_full;
    prod_t              prod_re, dly_out, b_sub, a_sub;
    logic [2*IQ_W-1:0]  sq_0i, sq_0q, sq_1i, sq_1q;
    logic [E_SMP_W-1:0] e_in, e_sub;
    logic [Q_CNT_W-1:0] a_cnt_next, b_cnt_next;
    logic [E_CNT_W-1:0] e_cnt_next;
    corr_t              sum_a_next, sum_b_next, r_sum, r_clamp;
    energy_t            energy_next;

    // --------------------------------------------------
    // Product stream and sliding sums
    // --------------------------------------------------
    always_comb begin
        hist_full = (hist_cnt == Q_CNT_W'(Q));
        d0_i = hist_ch0_i[hist_ptr];
        d0_q = hist_ch0_q[hist_ptr];
        d1_i = hist_ch1_i[hist_ptr];
        d1_q = hist_ch1_q[hist_ptr];

        // Re{x[n-Q] * conj(x[n])} over both antennas
        prod_re = d0_i * ch0_i_i + d0_q * ch0_q_i + d1_i * ch1_i_i + d1_q * ch1_q_i;

        dly_full  = (dly_cnt == P_CNT_W'(P_LEN));
        dly_valid = hist_full && dly_full;
        dly_out   = dly_ring[dly_ptr];

        b_full = (b_cnt == Q_CNT_W'(Q));
        b_sub  = b_full ? b_ring[b_ptr] : '0;
        sum_b_next = sum_b;
        b_cnt_next = b_cnt;
        if (hist_full) begin
            sum_b_next = sum_b + prod_re - b_sub;
            if (!b_full) begin
                b_cnt_next = b_cnt + 1'b1;
            end
        end

        a_full = (a_cnt == Q_CNT_W'(Q));
        a_sub  = a_full ? a_ring[a_ptr] : '0;
        sum_a_next = sum_a;
        a_cnt_next = a_cnt;
        if (dly_valid) begin
            sum_a_next = sum_a + dly_out - a_sub;
            if (!a_full) begin
                a_cnt_next = a_cnt + 1'b1;
            end
        end

        // Energy of the newest sample, both antennas
        sq_0i = ch0_i_i * ch0_i_i;
        sq_0q = ch0_q_i * ch0_q_i;
        sq_1i = ch1_i_i * ch1_i_i;
        sq_1q = ch1_q_i * ch1_q_i;
        e_in  = sq_0i + sq_0q + sq_1i + sq_1q;

        e_full = (e_cnt == E_CNT_W'(E_LEN));
        e_sub  = e_full ? e_ring[e_ptr] : '0;
        energy_next = energy_sum + energy_t'(e_in) - energy_t'(e_sub);
        e_cnt_next  = e_full ? e_cnt : e_cnt + 1'b1;

        win_full = (a_cnt_next == Q_CNT_W'(Q)) && (b_cnt_next == Q_CNT_W'(Q)) &&
                   (e_cnt_next == E_CNT_W'(E_LEN));

        r_sum   = sum_a_next + sum_b_next;
        r_clamp = r_sum[CORR_W-1] ? '0 : r_sum;
    end

    // --------------------------------------------------
    // Pointers, fill counts and sums
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_ptr       <= '0;
            hist_cnt       <= '0;
            dly_ptr        <= '0;
            dly_cnt        <= '0;
            b_ptr          <= '0;
            b_cnt          <= '0;
            sum_b          <= '0;
            a_ptr          <= '0;
            a_cnt          <= '0;
            sum_a          <= '0;
            e_ptr          <= '0;
            e_cnt          <= '0;
            energy_sum     <= '0;
            sample_idx     <= '0;
            metric_valid_o <= 1'b0;
        end else begin
            metric_valid_o <= 1'b0;
            if (in_valid_i) begin
                hist_ptr <= (hist_ptr == Q_PTR_W'(Q - 1)) ? '0 : hist_ptr + 1'b1;
                if (!hist_full) begin
                    hist_cnt <= hist_cnt + 1'b1;
                end
                if (hist_full) begin
                    dly_ptr <= (dly_ptr == P_PTR_W'(P_LEN - 1)) ? '0 : dly_ptr + 1'b1;
                    b_ptr   <= (b_ptr == Q_PTR_W'(Q - 1)) ? '0 : b_ptr + 1'b1;
                    if (!dly_full) begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                if (dly_valid) begin
                    a_ptr <= (a_ptr == Q_PTR_W'(Q - 1)) ? '0 : a_ptr + 1'b1;
                end
                e_ptr          <= (e_ptr == E_PTR_W'(E_LEN - 1)) ? '0 : e_ptr + 1'b1;
                b_cnt          <= b_cnt_next;
                a_cnt          <= a_cnt_next;
                e_cnt          <= e_cnt_next;
                sum_b          <= sum_b_next;
                sum_a          <= sum_a_next;
                energy_sum     <= energy_next;
                sample_idx     <= sample_idx + 1'b1;
                metric_valid_o <= win_full;
            end
        end
    end

    // Ring contents and the metric payload
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            hist_ch0_i[hist_ptr] <= ch0_i_i;
            hist_ch0_q[hist_ptr] <= ch0_q_i;
            hist_ch1_i[hist_ptr] <= ch1_i_i;
            hist_ch1_q[hist_ptr] <= ch1_q_i;
            e_ring[e_ptr]        <= e_in;
            if (hist_full) begin
                dly_ring[dly_ptr] <= prod_re;
                b_ring[b_ptr]     <= prod_re;
            end
            if (dly_valid) begin
                a_ring[a_ptr] <= dly_out;
            end
            metric_r_o      <= r_clamp;
            metric_energy_o <= energy_next;
            metric_idx_o    <= sample_idx - idx_t'(`MINN_WINDOW_DELAY);
        end
    end

endmodule

/* rtl/minn_pkg.sv */
`include "minn_settings.svh"

package minn_pkg;

    // --------------------------------------------------
    // Widths derived from the sample format
    // --------------------------------------------------
    localparam int IQ_W = `MINN_WIDTH;

    // Four IQ products summed over two antennas
    localparam int PROD_W = 2 * IQ_W + 2;

    // Q products plus two guard bits
    localparam int CORR_W = PROD_W + $clog2(`MINN_Q + 1) + 2;

    // Per-sample energy over both antennas, summed over 3Q samples
    localparam int ENERGY_W = 2 * IQ_W + 1 + $clog2(3 * `MINN_Q + 1);

    localparam int RATIO_W = CORR_W + 15;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic signed [IQ_W-1:0]   iq_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [CORR_W-1:0] corr_t;
    typedef logic [ENERGY_W-1:0]      energy_t;
    typedef logic [RATIO_W-1:0]       ratio_t;
    typedef logic [31:0]              idx_t;

    typedef enum logic [1:0] {
        GATE_ARMED,
        GATE_OPEN,
        GATE_HOLDOFF
    } gate_state_t;

endpackage

/* rtl/minn_settings.svh */
`ifndef MINN_SETTINGS_SVH
`define MINN_SETTINGS_SVH

// Bits per I or Q component
`define MINN_WIDTH 12

// FFT length, must be a multiple of 4
`define MINN_N_FFT 64

// Quarter symbol length
`define MINN_Q (`MINN_N_FFT / 4)

// Square root of the gate threshold in Q1.15
`define MINN_K_Q15 14666

// Accepted samples to wait after a gate closes
`define MINN_HOLDOFF `MINN_N_FFT

// Alignment delay and depth of the replay ring
`define MINN_BUF_LEN (8 * `MINN_Q)

// Current sample back to the start of its metric window
`define MINN_WINDOW_DELAY (4 * `MINN_Q - 1)

`endif
